//--- build.f
ow_bus_pkg.sv
ds18b20_pkg.sv
us_tick_gen.sv
ow_bit_engine.sv
ds18b20_sequencer.sv
temp_bcd_format.sv
ds18b20_reader.sv
ow_bit_engine_assertions.sv
ds18b20_sensor_model.sv
tb_ds18b20_reader.sv

//--- ds18b20_pkg.sv
package ds18b20_pkg;

  // --------------------
  // command bytes
  // --------------------
  localparam logic [7:0] CMD_SKIP_ROM     = 8'hCC;
  localparam logic [7:0] CMD_CONVERT_T    = 8'h44;
  localparam logic [7:0] CMD_READ_SCRATCH = 8'hBE;

  // --------------------
  // data types
  // --------------------

  // scratchpad bytes 0 and 1, bit 12 is the sign, [3:0] the fraction
  typedef logic [15:0] raw_temp_t;

  // one decimal digit
  typedef logic [3:0] bcd_digit_t;

  // read slots allowed while the conversion runs
  localparam int CONVERT_POLL_MAX = 1000;

endpackage

//--- ds18b20_reader.sv
`timescale 1ns/1ps

module ds18b20_reader
  import ow_bus_pkg::*;
  import ds18b20_pkg::*;
#(
  parameter int CLK_PER_US   = 50,
  parameter int INIT_CREDITS = 2
) (
  input  logic       clk,
  input  logic       rst_n,
  output logic       ow_pull_low,  // 1 = master drives the line low
  input  logic       ow_sense,     // resolved line level
  input  logic       credit,
  output logic       sample_valid,
  output logic       sample_neg,
  output bcd_digit_t sample_hundreds,
  output bcd_digit_t sample_tens,
  output bcd_digit_t sample_ones,
  output bcd_digit_t sample_tenths
);

  logic      us_tick;
  logic      op_start;
  ow_op_t    op;
  logic      op_busy;
  logic      op_done;
  logic      op_bit;
  logic      raw_valid;
  raw_temp_t raw_temp;

  us_tick_gen #(.CLK_PER_US(CLK_PER_US)) tick0 (.clk, .rst_n, .us_tick);

  ow_bit_engine eng0 (
    .clk, .rst_n, .us_tick, .op_start, .op, .op_busy, .op_done, .op_bit,
    .ow_pull_low, .ow_sense
  );

  ds18b20_sequencer #(.INIT_CREDITS(INIT_CREDITS)) seq0 (
    .clk, .rst_n, .op_start, .op, .op_busy, .op_done, .op_bit,
    .raw_valid, .raw_temp, .credit
  );

  temp_bcd_format fmt0 (
    .clk, .rst_n, .raw_valid, .raw_temp, .sample_valid, .sample_neg,
    .sample_hundreds, .sample_tens, .sample_ones, .sample_tenths
  );

endmodule

//--- ds18b20_sensor_model.sv
`timescale 1ns/1ps

module ds18b20_sensor_model
  import ds18b20_pkg::*;
#(
  parameter int CLK_PER_US = 4,
  parameter int SEED       = 0
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      enable,     // 0 suppresses the presence pulse
  input  logic      line,       // resolved bus level
  output logic      pull_low,
  output logic      drawn_stb,
  output raw_temp_t drawn_raw
);

  typedef enum logic [1:0] {M_IDLE, M_CMD, M_POLL, M_READ} mode_t;

  localparam int RESET_MIN = 400 * CLK_PER_US;  // longer lows are reset pulses
  localparam int ONE_MAX   = 15 * CLK_PER_US;   // write 1 is a short low
  localparam int ZERO_HOLD = 30 * CLK_PER_US;

  mode_t      mode;
  int         seed = SEED;
  int         low_cnt;
  int         drive_cnt;
  int         pres_wait;
  int         polls_left;
  int         draws;
  int         rd_idx;
  int         rx_cnt;
  int         mag;
  int         temp;
  logic       line_q;
  logic       measuring;  // low pulse opened by the master
  logic [7:0] rx_byte;
  logic [7:0] byte_in;
  raw_temp_t  scratch;

  always @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      mode       <= M_IDLE;
      line_q     <= 1'b1;
      measuring  <= 1'b0;
      low_cnt    <= 0;
      drive_cnt  <= 0;
      pres_wait  <= 0;
      polls_left <= 0;
      draws      <= 0;
      rd_idx     <= 0;
      rx_cnt     <= 0;
      rx_byte    <= '0;
      scratch    <= '0;
      pull_low   <= 1'b0;
      drawn_stb  <= 1'b0;
      drawn_raw  <= '0;
    end
    else
    begin
      line_q    <= line;
      drawn_stb <= 1'b0;
      low_cnt   <= low_cnt + 1;

      if (drive_cnt == 1)
        pull_low <= 1'b0;
      if (drive_cnt != 0)
        drive_cnt <= drive_cnt - 1;

      // presence pulse some 30 us after reset release
      if (pres_wait == 1)
      begin
        pull_low  <= 1'b1;
        drive_cnt <= 120 * CLK_PER_US;
      end
      if (pres_wait != 0)
        pres_wait <= pres_wait - 1;

      // --------------------
      // slot start
      // --------------------
      if (line_q && !line && !pull_low)
      begin
        measuring <= 1'b1;
        low_cnt   <= 1;
        if (mode == M_POLL)
        begin
          if (polls_left == 0)
            mode <= M_IDLE;  // conversion done, line left high
          else
          begin
            polls_left <= polls_left - 1;
            pull_low   <= 1'b1;
            drive_cnt  <= ZERO_HOLD;
          end
        end
        else if (mode == M_READ)
        begin
          if (!scratch[rd_idx])
          begin
            pull_low  <= 1'b1;
            drive_cnt <= ZERO_HOLD;
          end
          rd_idx <= rd_idx + 1;
          if (rd_idx == 15)
            mode <= M_IDLE;
        end
      end

      // --------------------
      // master releases the line
      // --------------------
      if (!line_q && line && measuring)
      begin
        measuring <= 1'b0;
        if (low_cnt >= RESET_MIN)
        begin
          mode   <= enable ? M_CMD : M_IDLE;
          rx_cnt <= 0;
          if (enable)
            pres_wait <= 30 * CLK_PER_US;
        end
        else if (mode == M_CMD)
        begin
          byte_in = {(low_cnt < ONE_MAX), rx_byte[7:1]};  // LSB first
          rx_byte <= byte_in;
          rx_cnt  <= rx_cnt + 1;
          if (rx_cnt == 7)
          begin
            rx_cnt <= 0;
            if (byte_in == CMD_CONVERT_T)
            begin
              mag = int'({$random(seed)} % 2001);  // up to +125.0 in 1/16
              if (draws % 3 == 1 || {$random(seed)} % 4 == 0)
                temp = -(mag % 881);  // down to -55.0
              else
                temp = mag;
              scratch    <= raw_temp_t'(temp);
              drawn_raw  <= raw_temp_t'(temp);
              drawn_stb  <= 1'b1;
              draws      <= draws + 1;
              polls_left <= 1 + int'({$random(seed)} % 5);
              mode       <= M_POLL;
            end
            else if (byte_in == CMD_READ_SCRATCH)
            begin
              rd_idx <= 0;
              mode   <= M_READ;
            end
            else if (byte_in != CMD_SKIP_ROM)
              mode <= M_IDLE;
          end
        end
      end
    end
  end

endmodule

//--- ds18b20_sequencer.sv
`timescale 1ns/1ps

module ds18b20_sequencer
  import ow_bus_pkg::*;
  import ds18b20_pkg::*;
#(
  parameter int INIT_CREDITS = 2
) (
  input  logic      clk,
  input  logic      rst_n,
  output logic      op_start,
  output ow_op_t    op,
  input  logic      op_busy,
  input  logic      op_done,
  input  logic      op_bit,
  output logic      raw_valid,
  output raw_temp_t raw_temp,
  input  logic      credit
);

  localparam int POLL_W   = $clog2(CONVERT_POLL_MAX);
  localparam int CREDIT_W = 8;

  typedef enum logic [3:0] {
    SQ_IDLE, SQ_RST1, SQ_SKIP1, SQ_CONV, SQ_POLL,
    SQ_RST2, SQ_SKIP2, SQ_RDCMD, SQ_RDBITS
  } sq_state_t;

  sq_state_t           state;
  logic                op_pend;   // one operation in flight
  logic [7:0]          tx_byte;   // shifted out LSB first
  logic [3:0]          bit_cnt;
  logic [POLL_W-1:0]   poll_cnt;
  logic [CREDIT_W-1:0] credit_cnt;
  logic                byte_last;
  logic                raw_release;

  assign byte_last   = (bit_cnt == 4'd7);
  assign raw_release = op_done && (state == SQ_RDBITS) && (bit_cnt == 4'd15);
  assign op_start    = (state != SQ_IDLE) && !op_pend && !op_busy;

  always_comb
  begin
    case (state)
      SQ_POLL, SQ_RDBITS: op = OP_READ;
      SQ_SKIP1, SQ_CONV, SQ_SKIP2, SQ_RDCMD:
        op = tx_byte[0] ? OP_WRITE1 : OP_WRITE0;
      default:            op = OP_RESET;
    endcase
  end

  // --------------------
  // command flow
  // --------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state      <= SQ_IDLE;
      op_pend    <= 1'b0;
      tx_byte    <= '0;
      bit_cnt    <= '0;
      poll_cnt   <= '0;
      credit_cnt <= CREDIT_W'(INIT_CREDITS);
      raw_valid  <= 1'b0;
    end
    else
    begin
      raw_valid  <= 1'b0;
      credit_cnt <= credit_cnt + CREDIT_W'(credit) - CREDIT_W'(raw_release);
      if (op_start)
        op_pend <= 1'b1;
      else if (op_done)
        op_pend <= 1'b0;

      if (op_done)
      begin
        case (state)
          SQ_RST1, SQ_RST2:
            if (op_bit)
            begin
              tx_byte <= CMD_SKIP_ROM;
              bit_cnt <= '0;
              state   <= (state == SQ_RST1) ? SQ_SKIP1 : SQ_SKIP2;
            end
            else
              state <= SQ_RST1;  // no presence, start over
          SQ_SKIP1, SQ_CONV, SQ_SKIP2, SQ_RDCMD:
          begin
            tx_byte <= tx_byte >> 1;
            bit_cnt <= bit_cnt + 1'b1;
            if (byte_last)
            begin
              bit_cnt <= '0;
              case (state)
                SQ_SKIP1:
                begin
                  tx_byte <= CMD_CONVERT_T;
                  state   <= SQ_CONV;
                end
                SQ_CONV:
                begin
                  poll_cnt <= '0;
                  state    <= SQ_POLL;
                end
                SQ_SKIP2:
                begin
                  tx_byte <= CMD_READ_SCRATCH;
                  state   <= SQ_RDCMD;
                end
                default: state <= SQ_RDBITS;
              endcase
            end
          end
          SQ_POLL:
            if (op_bit)
              state <= SQ_RST2;  // conversion finished
            else if (poll_cnt == POLL_W'(CONVERT_POLL_MAX - 1))
              state <= SQ_RST1;
            else
              poll_cnt <= poll_cnt + 1'b1;
          SQ_RDBITS:
          begin
            bit_cnt <= bit_cnt + 1'b1;
            if (raw_release)
            begin
              bit_cnt   <= '0;
              raw_valid <= 1'b1;
              state     <= SQ_IDLE;
            end
          end
          default: ;
        endcase
      end
      else if (state == SQ_IDLE && credit_cnt != '0)
        state <= SQ_RST1;
    end
  end

  // reading arrives LSB first
  always_ff @(posedge clk)
  begin
    if (op_done && state == SQ_RDBITS)
      raw_temp <= {op_bit, raw_temp[15:1]};
  end

endmodule

//--- ow_bit_engine.sv
`timescale 1ns/1ps

module ow_bit_engine
  import ow_bus_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   us_tick,
  input  logic   op_start,
  input  ow_op_t op,
  output logic   op_busy,
  output logic   op_done,
  output logic   op_bit,
  output logic   ow_pull_low,
  input  logic   ow_sense
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_ALIGN,    // wait for a tick so the low pulse is whole microseconds
    ST_LOW,
    ST_WAIT,     // released, up to the sample point or slot end
    ST_RECOVER
  } eng_state_t;

  eng_state_t          state;
  ow_op_t              op_q;
  logic [US_CNT_W-1:0] us_cnt;
  logic [US_CNT_W-1:0] phase_len;
  logic                phase_end;
  logic                sense_q;

  // --------------------
  // phase lengths
  // --------------------
  always_comb
  begin
    phase_len = US_CNT_W'(SLOT_LOW_US);
    case (state)
      ST_LOW:
        case (op_q)
          OP_RESET:  phase_len = US_CNT_W'(RESET_LOW_US);
          OP_WRITE0: phase_len = US_CNT_W'(WRITE_SLOT_US);
          default:   phase_len = US_CNT_W'(SLOT_LOW_US);
        endcase
      ST_WAIT:
        case (op_q)
          OP_RESET:  phase_len = US_CNT_W'(PRESENCE_WAIT_US);
          OP_WRITE0: phase_len = US_CNT_W'(SLOT_LOW_US);  // short recovery
          OP_WRITE1: phase_len = US_CNT_W'(WRITE_SLOT_US);
          default:   phase_len = US_CNT_W'(READ_SAMPLE_US);
        endcase
      ST_RECOVER:
        phase_len = (op_q == OP_RESET) ? US_CNT_W'(RESET_RECOVER_US)
                                       : US_CNT_W'(READ_RECOVER_US);
      default: ;
    endcase
  end

  assign phase_end = us_tick && (us_cnt == phase_len - 1'b1);

  // --------------------
  // phase machine
  // --------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state       <= ST_IDLE;
      op_q        <= OP_RESET;
      us_cnt      <= '0;
      sense_q     <= 1'b1;  // idle bus is high
      op_busy     <= 1'b0;
      op_done     <= 1'b0;
      op_bit      <= 1'b0;
      ow_pull_low <= 1'b0;
    end
    else
    begin
      sense_q <= ow_sense;
      op_done <= 1'b0;
      if (us_tick)
        us_cnt <= us_cnt + 1'b1;
      case (state)
        ST_IDLE:
          if (op_start)
          begin
            op_q    <= op;
            op_busy <= 1'b1;
            state   <= ST_ALIGN;
          end
        ST_ALIGN:
          if (us_tick)
          begin
            ow_pull_low <= 1'b1;
            us_cnt      <= '0;
            state       <= ST_LOW;
          end
        ST_LOW:
          if (phase_end)
          begin
            ow_pull_low <= 1'b0;  // release, pull-up takes the line high
            us_cnt      <= '0;
            state       <= ST_WAIT;
          end
        ST_WAIT:
          if (phase_end)
          begin
            us_cnt <= '0;
            if (op_q == OP_RESET || op_q == OP_READ)
            begin
              op_bit <= (op_q == OP_RESET) ? ~sense_q : sense_q;  // low = present
              state  <= ST_RECOVER;
            end
            else
            begin
              op_busy <= 1'b0;
              op_done <= 1'b1;
              state   <= ST_IDLE;
            end
          end
        ST_RECOVER:
          if (phase_end)
          begin
            op_busy <= 1'b0;
            op_done <= 1'b1;
            state   <= ST_IDLE;
          end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

//--- ow_bit_engine_assertions.sv
`timescale 1ns/1ps

module ow_bit_engine_assertions
  import ow_bus_pkg::*;
(
  input logic clk,
  input logic rst_n,
  input logic us_tick,
  input logic op_start,
  input logic op_busy,
  input logic op_done,
  input logic ow_pull_low
);

  int fail_cnt = 0;
  int low_ticks;  // microseconds the master has held the line low

  always @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      low_ticks <= 0;
    else if (!ow_pull_low)
      low_ticks <= 0;
    else if (us_tick)
      low_ticks <= low_ticks + 1;
  end

  start_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
    op_start |-> !op_busy)
  else
  begin
    fail_cnt++;
    $error("op_start raised while the engine is busy");
  end

  done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    op_done |=> !op_done)
  else
  begin
    fail_cnt++;
    $error("op_done held for more than one cycle");
  end

  pull_bounded: assert property (@(posedge clk) disable iff (!rst_n)
    low_ticks <= RESET_LOW_US + 1)
  else
  begin
    fail_cnt++;
    $error("line held low longer than a reset pulse");
  end

endmodule

//--- ow_bus_pkg.sv
package ow_bus_pkg;

  // --------------------
  // slot operations
  // --------------------
  typedef enum logic [1:0] {
    OP_RESET  = 2'd0,  // reset pulse plus presence detect
    OP_WRITE0 = 2'd1,
    OP_WRITE1 = 2'd2,
    OP_READ   = 2'd3
  } ow_op_t;

  // --------------------
  // slot timing in us
  // --------------------
  localparam int RESET_LOW_US     = 500;
  localparam int PRESENCE_WAIT_US = 100;  // release to presence sample
  localparam int RESET_RECOVER_US = 400;

  localparam int SLOT_LOW_US      = 1;    // opening pulse of write 1 / read
  localparam int WRITE_SLOT_US    = 80;
  localparam int READ_SAMPLE_US   = 10;   // counted from release
  localparam int READ_RECOVER_US  = 55;

  // wide enough for the longest phase
  localparam int US_CNT_W         = 10;

endpackage

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_ds18b20_reader \
  -f build.f -o sim_tb
./obj_dir/sim_tb +verilator+error+limit+100 | tee sim.log
if grep -q "All tests passed" sim.log; then
  exit 0
fi
echo "simulation reported failure, see sim.log"
exit 1

//--- tb_ds18b20_reader.sv
`timescale 1ns/1ps

module tb_ds18b20_reader
  import ds18b20_pkg::*;
();

  localparam int CLK_PER_US   = 4;
  localparam int INIT_CREDITS = 2;
  localparam int SEED         = 32'hed04_a3a3;
  localparam int SAMPLE_US    = 8000;   // one full reading plus margin
  localparam int QUIET_US     = 20000;
  localparam int IDLE_US      = 2000;
  localparam int NOPRES_US    = 3000;
  localparam int N_RANDOM     = 7;
  localparam int WATCHDOG_US  = 12 * SAMPLE_US + QUIET_US + IDLE_US + NOPRES_US;

  logic       clk;
  logic       rst_n;
  logic       credit;
  logic       model_en;
  logic       ow_pull_low;
  logic       model_pull;
  logic       ow_line;
  logic       pull_q;
  logic       sample_valid;
  logic       sample_neg;
  bcd_digit_t sample_hundreds;
  bcd_digit_t sample_tens;
  bcd_digit_t sample_ones;
  bcd_digit_t sample_tenths;
  logic       drawn_stb;
  raw_temp_t  drawn_raw;
  raw_temp_t  raw_now;
  raw_temp_t  exp_q[$];
  int         n_samples;
  int         n_neg;
  int         n_pulls;
  int         n_checks;
  int         n_errors;
  int         pulls0;

  assign ow_line = ~ow_pull_low & ~model_pull;  // wired-AND with pull-up

  ds18b20_reader #(.CLK_PER_US(CLK_PER_US), .INIT_CREDITS(INIT_CREDITS)) dut0 (
    .clk, .rst_n, .ow_pull_low, .ow_sense(ow_line), .credit, .sample_valid,
    .sample_neg, .sample_hundreds, .sample_tens, .sample_ones, .sample_tenths
  );

  ds18b20_sensor_model #(.CLK_PER_US(CLK_PER_US), .SEED(SEED)) sensor0 (
    .clk, .rst_n, .enable(model_en), .line(ow_line), .pull_low(model_pull),
    .drawn_stb, .drawn_raw
  );

  bind ow_bit_engine ow_bit_engine_assertions chk0 (
    .clk(clk), .rst_n(rst_n), .us_tick(us_tick), .op_start(op_start),
    .op_busy(op_busy), .op_done(op_done), .ow_pull_low(ow_pull_low)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // --------------------
  // expected digits
  // --------------------
  task automatic check_sample(input raw_temp_t raw);
    logic neg;
    int   sixteenths;
    int   whole;
    int   tenths;
    neg        = raw[12];
    sixteenths = neg ? -int'($signed(raw)) : int'(raw);  // magnitude in 1/16 C
    whole      = sixteenths / 16;
    tenths     = (sixteenths % 16) * 10 / 16;
    n_checks++;
    assert (sample_neg == neg && sample_hundreds == whole / 100
            && sample_tens == (whole / 10) % 10 && sample_ones == whole % 10
            && sample_tenths == tenths)
    else
    begin
      n_errors++;
      $display("error %0t: raw %h gave sign %0b digits %0d%0d%0d.%0d, expected %0b %0d.%0d",
               $time, raw, sample_neg, sample_hundreds, sample_tens, sample_ones,
               sample_tenths, neg, whole, tenths);
    end
  endtask

  // drawn readings in, samples out, reset pulses counted
  always @(negedge clk)
  begin
    if (ow_pull_low && !pull_q)
      n_pulls++;
    pull_q = ow_pull_low;
    if (drawn_stb)
      exp_q.push_back(drawn_raw);
    if (sample_valid)
    begin
      n_samples++;
      n_checks++;
      assert (exp_q.size() > 0)
      else
      begin
        n_errors++;
        $display("sample arrived at %0t although the sensor drew no reading", $time);
      end
      if (exp_q.size() > 0)
      begin
        raw_now = exp_q.pop_front();
        if (raw_now[12])
          n_neg++;
        check_sample(raw_now);
      end
    end
  end

  task automatic wait_samples(input int n);
    while (n_samples < n)
      @(negedge clk);
  endtask

  task automatic pulse_credit();
    @(negedge clk);
    credit = 1'b1;
    @(negedge clk);
    credit = 1'b0;
  endtask

  // bus stays released and no sample appears
  task automatic expect_idle(input int us);
    int   start;
    logic busy_seen;
    start     = n_samples;
    busy_seen = 1'b0;
    repeat (us * CLK_PER_US)
    begin
      @(negedge clk);
      busy_seen = busy_seen | ow_pull_low;
    end
    n_checks++;
    assert (!busy_seen && n_samples == start)
    else
    begin
      n_errors++;
      $display("error %0t: bus active or sample seen without credit", $time);
    end
  endtask

  // --------------------
  // test sequence
  // --------------------
  initial
  begin
    rst_n     = 1'b0;
    credit    = 1'b0;
    model_en  = 1'b1;
    pull_q    = 1'b0;
    n_samples = 0;
    n_neg     = 0;
    n_pulls   = 0;
    n_checks  = 0;
    n_errors  = 0;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;

    wait_samples(INIT_CREDITS);  // back-pressure
    expect_idle(QUIET_US);
    pulse_credit();
    wait_samples(INIT_CREDITS + 1);
    expect_idle(IDLE_US);

    repeat (N_RANDOM) pulse_credit();
    wait_samples(INIT_CREDITS + 1 + N_RANDOM);

    // sensor silent on reset
    model_en = 1'b0;
    pulls0   = n_pulls;
    pulse_credit();
    repeat (NOPRES_US * CLK_PER_US) @(negedge clk);
    n_checks++;
    assert (n_samples == INIT_CREDITS + 1 + N_RANDOM && n_pulls - pulls0 >= 2)
    else
    begin
      n_errors++;
      $display("error %0t: without presence got %0d samples and %0d reset pulses",
               $time, n_samples, n_pulls - pulls0);
    end
    model_en = 1'b1;
    wait_samples(INIT_CREDITS + 2 + N_RANDOM);

    n_checks++;
    assert (n_neg > 0 && exp_q.size() == 0)
    else
    begin
      n_errors++;
      $display("no negative reading was checked or readings were left unmatched");
    end

    $display("checks %0d, errors %0d, engine assertion failures %0d",
             n_checks, n_errors, dut0.eng0.chk0.fail_cnt);
    if (n_errors == 0 && dut0.eng0.chk0.fail_cnt == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

  initial
  begin
    repeat (WATCHDOG_US * CLK_PER_US) @(posedge clk);
    $display("timeout after %0d us with %0d samples seen", WATCHDOG_US, n_samples);
    $display("Some tests failed");
    $finish;
  end

endmodule

//--- temp_bcd_format.sv
`timescale 1ns/1ps

module temp_bcd_format
  import ds18b20_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       raw_valid,
  input  raw_temp_t  raw_temp,
  output logic       sample_valid,
  output logic       sample_neg,
  output bcd_digit_t sample_hundreds,
  output bcd_digit_t sample_tens,
  output bcd_digit_t sample_ones,
  output bcd_digit_t sample_tenths
);

  raw_temp_t  mag;
  logic [7:0] int_part;
  logic [7:0] frac_x10;

  always_comb
  begin
    mag      = raw_temp[12] ? (~raw_temp + 16'd1) : raw_temp;  // two's complement
    int_part = mag[11:4];
    frac_x10 = {4'b0000, mag[3:0]} * 8'd10;  // tenths live in [7:4]
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      sample_valid <= 1'b0;
    else
      sample_valid <= raw_valid;
  end

  always_ff @(posedge clk)
  begin
    if (raw_valid)
    begin
      sample_neg      <= raw_temp[12];
      sample_hundreds <= bcd_digit_t'(int_part / 8'd100);
      sample_tens     <= bcd_digit_t'((int_part % 8'd100) / 8'd10);
      sample_ones     <= bcd_digit_t'(int_part % 8'd10);
      sample_tenths   <= frac_x10[7:4];
    end
  end

endmodule

//--- us_tick_gen.sv
`timescale 1ns/1ps

module us_tick_gen #(
  parameter int CLK_PER_US = 50
) (
  input  logic clk,
  input  logic rst_n,
  output logic us_tick
);

  localparam int CNT_W = (CLK_PER_US > 1) ? $clog2(CLK_PER_US) : 1;

  logic [CNT_W-1:0] cnt;  // modulo CLK_PER_US

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cnt     <= '0;
      us_tick <= 1'b0;
    end
    else if (cnt == CNT_W'(CLK_PER_US - 1))
    begin
      cnt     <= '0;
      us_tick <= 1'b1;  // one clock per wrap
    end
    else
    begin
      cnt     <= cnt + 1'b1;
      us_tick <= 1'b0;
    end
  end

endmodule
